/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and instruction words share one width
`define WORD_SIZE 16

// general purpose register file
`define NUM_REGS 8
`define REG_BITS 3

// instruction word fields
`define OPCODE_BITS 3
`define IMM_BITS 9

`endif

/* isaPkg.sv */
`include "cpu_defines.svh"

package isaPkg;

    typedef enum logic [`OPCODE_BITS-1:0] {
        mv    = 3'b000, // rX <= operand
        mvtB  = 3'b001, // mvt with mode set, branch with mode clear
        add   = 3'b010,
        sub   = 3'b011,
        ld    = 3'b100, // rX <= mem[rY]
        st    = 3'b101, // mem[rY] <= rX
        andOp = 3'b110,
        other = 3'b111  // runs as a no-op
    } opcode_t;

    // III M XXX DDDDDDDDD
    typedef struct packed {
        opcode_t               opcode;
        logic                  mode; // set for the immediate form
        logic [`REG_BITS-1:0]  rX;
        logic [`IMM_BITS-1:0]  imm; // signed, extended in decode
    } immForm_t;

    // III M XXX 000000 YYY
    typedef struct packed {
        opcode_t                        opcode;
        logic                           mode;
        logic [`REG_BITS-1:0]           rX;
        logic [`IMM_BITS-`REG_BITS-1:0] pad; // zero in a well formed word
        logic [`REG_BITS-1:0]           rY;
    } regForm_t;

    typedef union packed {
        immForm_t immForm;
        regForm_t regForm;
    } instrWord_t;

    typedef enum logic [2:0] {
        aluNone, aluPass, aluPassHigh, aluAdd, aluSub, aluAnd, aluBranch
    } aluOp_t;

endpackage

/* pipePkg.sv */
`include "cpu_defines.svh"

package pipePkg;

    // decode to execute record
    typedef struct packed {
        logic                  valid;     // low for a bubble
        isaPkg::aluOp_t        aluOp;
        logic [`REG_BITS-1:0]  rX;        // destination, also store source
        logic                  writeback; // result goes to rX
        logic                  read;      // load
        logic                  write;     // store
        logic [`WORD_SIZE-1:0] op1;       // value of rX
        logic [`WORD_SIZE-1:0] op2;       // rY value or extended immediate
        logic [`WORD_SIZE-1:0] pc;        // address of this instruction
    } decoded_t;

    // execute to memory to writeback record
    typedef struct packed {
        logic                  valid;
        logic [`REG_BITS-1:0]  rX;
        logic                  writeback;
        logic                  read;
        logic                  write;
        logic [`WORD_SIZE-1:0] address; // data address for ld and st
        logic [`WORD_SIZE-1:0] result;  // alu result, store data or load data
    } memReq_t;

endpackage

/* regFileBus.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

interface regFileBus;
    logic [`REG_BITS-1:0]  readAddr1;   // rX port
    logic [`REG_BITS-1:0]  readAddr2;   // rY port
    logic [`WORD_SIZE-1:0] readData1;
    logic [`WORD_SIZE-1:0] readData2;
    logic                  writeEnable;
    logic [`REG_BITS-1:0]  writeAddr;
    logic [`WORD_SIZE-1:0] writeData;

    modport decoder (output readAddr1, readAddr2,
                     input  readData1, readData2);

    modport writer (output writeEnable, writeAddr, writeData);

    modport regs (input  readAddr1, readAddr2, writeEnable, writeAddr, writeData,
                  output readData1, readData2);

endinterface

/* dataBus.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

interface dataBus;
    logic                  valid;     // request pending
    logic                  ready;     // memory accepts on this edge
    logic                  write;     // store when high, load when low
    logic [`WORD_SIZE-1:0] address;
    logic [`WORD_SIZE-1:0] writeData;
    logic [`WORD_SIZE-1:0] readData;  // sampled on the transfer edge

    // request side, held stable until valid and ready meet
    modport master (output valid, write, address, writeData,
                    input  ready, readData);

endinterface

/* regFile.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile (
    input logic      Clock,
    input logic      Reset,
    regFileBus.regs  bus
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS]; // r0 to r7, all ordinary

    // same cycle write wins over the stored value
    function automatic logic [`WORD_SIZE-1:0] readPort(input logic [`REG_BITS-1:0] addr);
        if (bus.writeEnable && bus.writeAddr == addr)
            return bus.writeData;
        return regs[addr];
    endfunction

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (bus.writeEnable) begin
            regs[bus.writeAddr] <= bus.writeData; // writeback port
        end
    end

    always_comb begin
        bus.readData1 = readPort(bus.readAddr1);
        bus.readData2 = readPort(bus.readAddr2);
    end

endmodule

/* frontEnd.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module frontEnd (
    input  logic                  Clock,
    input  logic                  Reset,
    input  logic [`WORD_SIZE-1:0] InstrIn,
    output logic [`WORD_SIZE-1:0] InstrAddr,
    input  logic                  hold,
    input  logic                  branchTaken,
    input  logic [`WORD_SIZE-1:0] branchTarget,
    regFileBus.decoder            rf,
    input  pipePkg::memReq_t      exRec,
    input  pipePkg::memReq_t      memRec,
    input  pipePkg::memReq_t      wbRec,
    output pipePkg::decoded_t     decoded
);

    logic [`WORD_SIZE-1:0] pc;         // next fetch address
    logic                  fetchValid; // fetch register holds a live word
    isaPkg::instrWord_t    fetchWord;
    logic [`WORD_SIZE-1:0] fetchPc;    // address of fetchWord
    logic [`WORD_SIZE-1:0] immExt;
    logic                  usesX;      // rX is read as an operand
    logic                  usesY;      // rY is read as an operand
    logic                  pendX;
    logic                  pendY;
    logic                  stall;

    // record will still write r
    function automatic logic writesReg(input pipePkg::memReq_t rec,
                                       input logic [`REG_BITS-1:0] r);
        return rec.valid && rec.writeback && rec.rX == r;
    endfunction

    assign InstrAddr    = pc;
    assign rf.readAddr1 = fetchWord.immForm.rX;
    assign rf.readAddr2 = fetchWord.regForm.rY;
    assign immExt = {{(`WORD_SIZE-`IMM_BITS){fetchWord.immForm.imm[`IMM_BITS-1]}},
                     fetchWord.immForm.imm};

    assign pendX = writesReg(exRec, fetchWord.immForm.rX) ||
                   writesReg(memRec, fetchWord.immForm.rX) ||
                   writesReg(wbRec, fetchWord.immForm.rX);
    assign pendY = writesReg(exRec, fetchWord.regForm.rY) ||
                   writesReg(memRec, fetchWord.regForm.rY) ||
                   writesReg(wbRec, fetchWord.regForm.rY);

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc         <= '0;
            fetchValid <= 1'b0;
        end else if (!hold) begin
            if (branchTaken) begin
                pc         <= branchTarget; // redirect, drop the word in flight
                fetchValid <= 1'b0;
            end else if (!stall) begin
                pc         <= pc + 1'b1;
                fetchValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (!hold && !branchTaken && !stall) begin
            fetchWord <= InstrIn; // word for the address shown last cycle
            fetchPc   <= pc;
        end
    end

    always_comb begin
        decoded       = '0;
        decoded.rX    = fetchWord.immForm.rX;
        decoded.pc    = fetchPc;
        decoded.op1   = rf.readData1;
        decoded.op2   = fetchWord.immForm.mode ? immExt : rf.readData2;
        decoded.aluOp = isaPkg::aluNone;
        usesX         = 1'b0;
        usesY         = !fetchWord.immForm.mode;
        case (fetchWord.immForm.opcode)
            isaPkg::mv: begin
                decoded.aluOp     = isaPkg::aluPass;
                decoded.writeback = 1'b1;
            end
            isaPkg::mvtB: begin
                decoded.op2 = immExt; // both forms take the low nine bits
                usesY       = 1'b0;
                if (fetchWord.immForm.mode) begin
                    decoded.aluOp     = isaPkg::aluPassHigh;
                    decoded.writeback = 1'b1;
                end else begin
                    decoded.aluOp = isaPkg::aluBranch;
                end
            end
            isaPkg::add, isaPkg::sub, isaPkg::andOp: begin
                usesX             = 1'b1;
                decoded.writeback = 1'b1;
                if (fetchWord.immForm.opcode == isaPkg::add)
                    decoded.aluOp = isaPkg::aluAdd;
                else if (fetchWord.immForm.opcode == isaPkg::sub)
                    decoded.aluOp = isaPkg::aluSub;
                else
                    decoded.aluOp = isaPkg::aluAnd;
            end
            isaPkg::ld: begin
                decoded.op2       = rf.readData2; // address always from rY
                usesY             = 1'b1;
                decoded.read      = 1'b1;
                decoded.writeback = 1'b1;
            end
            isaPkg::st: begin
                decoded.op2   = rf.readData2;
                usesX         = 1'b1; // store data
                usesY         = 1'b1;
                decoded.write = 1'b1;
            end
            default: usesY = 1'b0; // opcode 111 flows through untouched
        endcase
        stall         = fetchValid && ((usesX && pendX) || (usesY && pendY));
        decoded.valid = fetchValid && !stall && !branchTaken; // bubble otherwise
    end

endmodule

/* executeStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module executeStage (
    input  logic                  Clock,
    input  logic                  Reset,
    input  logic                  hold,
    input  pipePkg::decoded_t     decoded,
    output logic                  branchTaken,
    output logic [`WORD_SIZE-1:0] branchTarget,
    output pipePkg::memReq_t      exRec
);

    pipePkg::decoded_t     exReg;  // instruction now in execute
    logic [`WORD_SIZE-1:0] result;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset)
            exReg <= '0;
        else if (!hold)
            exReg <= decoded; // frozen while memory waits
    end

    // relative to the branch's own address plus one
    assign branchTarget = exReg.pc + 1'b1 + exReg.op2;

    // one cycle only, hold keeps the branch here without firing
    assign branchTaken = exReg.valid && exReg.aluOp == isaPkg::aluBranch && !hold;

    always_comb begin
        case (exReg.aluOp)
            isaPkg::aluPass:     result = exReg.op2;
            isaPkg::aluPassHigh: result = {exReg.op2[`WORD_SIZE/2-1:0],
                                           {(`WORD_SIZE/2){1'b0}}}; // low byte cleared
            isaPkg::aluAdd:      result = exReg.op1 + exReg.op2;
            isaPkg::aluSub:      result = exReg.op1 - exReg.op2;
            isaPkg::aluAnd:      result = exReg.op1 & exReg.op2;
            isaPkg::aluBranch:   result = branchTarget;
            default:             result = exReg.op1; // store data rides here
        endcase
    end

    always_comb begin
        exRec.valid     = exReg.valid;
        exRec.rX        = exReg.rX;
        exRec.writeback = exReg.writeback;
        exRec.read      = exReg.read;
        exRec.write     = exReg.write;
        exRec.address   = exReg.op2; // rY value for ld and st
        exRec.result    = result;
    end

endmodule

/* memWriteback.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memWriteback (
    input  logic             Clock,
    input  logic             Reset,
    input  pipePkg::memReq_t exRec,
    output pipePkg::memReq_t memRec,
    output pipePkg::memReq_t wbRec,
    output logic             hold,
    dataBus.master           data,
    regFileBus.writer        rf
);

    pipePkg::memReq_t wbNext;
    logic             memAccess; // ld or st sitting in memory

    assign memAccess = memRec.valid && (memRec.read || memRec.write);

    // whole pipe waits until the data port takes the request
    assign hold = memAccess && !data.ready;

    assign data.valid     = memAccess;
    assign data.write     = memRec.valid && memRec.write;
    assign data.address   = memRec.address;
    assign data.writeData = memRec.result;

    always_comb begin
        wbNext = memRec;
        if (memRec.read)
            wbNext.result = data.readData; // load data on the transfer edge
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            memRec <= '0;
            wbRec  <= '0;
        end else if (!hold) begin
            memRec <= exRec;
            wbRec  <= wbNext;
        end
    end

    // write lands at the end of the writeback cycle
    // the register file bypass makes it visible to decode right away
    assign rf.writeEnable = wbRec.valid && wbRec.writeback;
    assign rf.writeAddr   = wbRec.rX;
    assign rf.writeData   = wbRec.result;

endmodule

/* cpuCore.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuCore (
    input  logic                  Clock,
    input  logic                  Reset,
    output logic [`WORD_SIZE-1:0] InstrAddr,
    input  logic [`WORD_SIZE-1:0] InstrIn,
    output logic                  DataValid,
    output logic                  DataWrite,
    output logic [`WORD_SIZE-1:0] DataAddr,
    output logic [`WORD_SIZE-1:0] DataOut,
    input  logic                  DataReady,
    input  logic [`WORD_SIZE-1:0] DataIn
);

    pipePkg::decoded_t     decoded;      // decode to execute
    pipePkg::memReq_t      exRec;        // in execute
    pipePkg::memReq_t      memRec;       // in memory
    pipePkg::memReq_t      wbRec;        // in writeback
    logic                  hold;         // data port back pressure
    logic                  branchTaken;
    logic [`WORD_SIZE-1:0] branchTarget;

    regFileBus rfBus ();
    dataBus    dBus ();

    // data port out to the pins
    assign DataValid      = dBus.valid;
    assign DataWrite      = dBus.write;
    assign DataAddr       = dBus.address;
    assign DataOut        = dBus.writeData;
    assign dBus.ready     = DataReady;
    assign dBus.readData  = DataIn;

    regFile i_regFile (
        .Clock (Clock),
        .Reset (Reset),
        .bus   (rfBus.regs)
    );

    frontEnd i_frontEnd (
        .Clock        (Clock),
        .Reset        (Reset),
        .InstrIn      (InstrIn),
        .InstrAddr    (InstrAddr),
        .hold         (hold),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .rf           (rfBus.decoder),
        .exRec        (exRec),
        .memRec       (memRec),
        .wbRec        (wbRec),
        .decoded      (decoded)
    );

    executeStage i_executeStage (
        .Clock        (Clock),
        .Reset        (Reset),
        .hold         (hold),
        .decoded      (decoded),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .exRec        (exRec)
    );

    memWriteback i_memWriteback (
        .Clock  (Clock),
        .Reset  (Reset),
        .exRec  (exRec),
        .memRec (memRec),
        .wbRec  (wbRec),
        .hold   (hold),
        .data   (dBus.master),
        .rf     (rfBus.writer)
    );

endmodule

/* cpuTb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTb;

    localparam int ImemBits   = 9;
    localparam int MaxWait    = 2000; // cycles allowed per expected store
    localparam int WithMem    = 1;
    localparam int WithBranch = 2;
    localparam int WithNop    = 4;

    logic                  Clock;
    logic                  Reset;
    logic [`WORD_SIZE-1:0] InstrAddr;
    logic [`WORD_SIZE-1:0] InstrIn;
    logic                  DataValid;
    logic                  DataWrite;
    logic [`WORD_SIZE-1:0] DataAddr;
    logic [`WORD_SIZE-1:0] DataOut;
    logic                  DataReady;
    logic [`WORD_SIZE-1:0] DataIn;

    logic [`WORD_SIZE-1:0] imem [2**ImemBits];
    logic [`WORD_SIZE-1:0] dmem [256];     // memory seen by the DUT
    logic [`WORD_SIZE-1:0] modelMem [256]; // copy used by the model
    logic [`WORD_SIZE-1:0] expAddr [$];    // model store stream
    logic [`WORD_SIZE-1:0] expData [$];
    logic [`WORD_SIZE-1:0] heldAddr;
    logic [`WORD_SIZE-1:0] heldOut;
    logic                  heldWrite;
    logic                  waiting;        // last cycle had valid without ready
    int progLen;
    int progNum;
    int readyPct;
    int errors;
    int storesSeen;
    int storesTotal;

    cpuCore i_cpuCore (
        .Clock     (Clock),
        .Reset     (Reset),
        .InstrAddr (InstrAddr),
        .InstrIn   (InstrIn),
        .DataValid (DataValid),
        .DataWrite (DataWrite),
        .DataAddr  (DataAddr),
        .DataOut   (DataOut),
        .DataReady (DataReady),
        .DataIn    (DataIn)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    task automatic checkValue(input string name, input logic [`WORD_SIZE-1:0] actual,
                              input logic [`WORD_SIZE-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    function automatic logic [`WORD_SIZE-1:0] encode(input isaPkg::opcode_t op,
            input logic mode, input logic [2:0] rx, input logic [8:0] low);
        isaPkg::instrWord_t w;
        w.immForm.opcode = op;
        w.immForm.mode   = mode;
        w.immForm.rX     = rx;
        w.immForm.imm    = low; // rY sits in the low three bits of the register form
        return w;
    endfunction

    function automatic logic [`WORD_SIZE-1:0] branchWord(input int offset);
        return encode(isaPkg::mvtB, 1'b0, 3'($urandom), 9'(offset));
    endfunction

    task automatic emit(input logic [`WORD_SIZE-1:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic emitRandom(input int kind);
        int               pick;
        logic [2:0]       rx;
        logic [2:0]       ry;
        logic             mode;
        isaPkg::opcode_t  op;
        pick = $urandom % 10;
        rx   = 3'($urandom);
        ry   = 3'($urandom);
        if ((kind & WithMem) != 0 && pick < 3) begin
            emit(encode(isaPkg::mv, 1'b1, ry, 9'($urandom % 256))); // address in range
            emit(encode(pick == 0 ? isaPkg::ld : isaPkg::st, 1'b0, rx, {6'b0, ry}));
        end else if ((kind & WithNop) != 0 && pick == 3) begin
            emit({3'b111, 13'($urandom)});
        end else begin
            case ($urandom % 5)
                0: op = isaPkg::mv;
                1: op = isaPkg::mvtB;
                2: op = isaPkg::add;
                3: op = isaPkg::sub;
                default: op = isaPkg::andOp;
            endcase
            mode = (op == isaPkg::mvtB) || ($urandom % 2 == 1); // mvt has no register form
            emit(encode(op, mode, rx, mode ? 9'($urandom) : {6'b0, ry}));
        end
    endtask

    // b C, skipped code, A ending in b out, C ending in b back to A
    task automatic emitBranchGroup(input int kind);
        int first;
        int aStart;
        int aExit;
        int cStart;
        first = progLen;
        emit('0);
        repeat (1 + $urandom % 3) emitRandom(kind);
        emit(encode(isaPkg::st, 1'b0, 3'($urandom), {6'b0, 3'($urandom)})); // never runs
        aStart = progLen;
        repeat (1 + $urandom % 5) emitRandom(kind);
        aExit = progLen;
        emit('0);
        cStart = progLen;
        repeat (1 + $urandom % 5) emitRandom(kind);
        emit(branchWord(aStart - progLen - 1));       // backward
        imem[first] = branchWord(cStart - first - 1); // forward over skipped code and A
        imem[aExit] = branchWord(progLen - aExit - 1);
    endtask

    task automatic buildProgram(input int kind);
        for (int a = 0; a < 2**ImemBits; a++)
            imem[a] = {3'b111, 13'(a)}; // no-op words tagged with their address
        progLen = 0;
        while (progLen < 240) begin
            if ((kind & WithBranch) != 0 && $urandom % 4 == 0)
                emitBranchGroup(kind);
            else
                emitRandom(kind);
        end
        for (int r = 0; r < `NUM_REGS; r++)
            emit(encode(isaPkg::st, 1'b0, 3'(r), {6'b0, 3'(r)})); // each register at its own value
        emit(branchWord(-1)); // park on itself
    endtask

    // instruction level model, fills the expected store stream
    task automatic runModel();
        isaPkg::instrWord_t    w;
        logic [`WORD_SIZE-1:0] regs [`NUM_REGS];
        logic [`WORD_SIZE-1:0] pc;
        logic [`WORD_SIZE-1:0] pcNext;
        logic [`WORD_SIZE-1:0] imm;
        logic [`WORD_SIZE-1:0] operand;
        int                    steps;
        logic                  done;
        for (int r = 0; r < `NUM_REGS; r++)
            regs[r] = '0;
        pc    = '0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 5000) begin
            w       = imem[pc[ImemBits-1:0]];
            imm     = {{(`WORD_SIZE-`IMM_BITS){w.immForm.imm[`IMM_BITS-1]}}, w.immForm.imm};
            operand = w.immForm.mode ? imm : regs[w.regForm.rY];
            pcNext  = pc + 16'd1;
            case (w.immForm.opcode)
                isaPkg::mv:    regs[w.immForm.rX] = operand;
                isaPkg::add:   regs[w.immForm.rX] = regs[w.immForm.rX] + operand;
                isaPkg::sub:   regs[w.immForm.rX] = regs[w.immForm.rX] - operand;
                isaPkg::andOp: regs[w.immForm.rX] = regs[w.immForm.rX] & operand;
                isaPkg::ld:    regs[w.immForm.rX] = modelMem[regs[w.regForm.rY][7:0]];
                isaPkg::mvtB: begin
                    if (w.immForm.mode) begin
                        regs[w.immForm.rX] = {w.immForm.imm[7:0], 8'h00};
                    end else begin
                        pcNext = pc + 16'd1 + imm;
                        done   = (imm == 16'hFFFF); // branch to itself ends the program
                    end
                end
                isaPkg::st: begin
                    expAddr.push_back(regs[w.regForm.rY]);
                    expData.push_back(regs[w.immForm.rX]);
                    modelMem[regs[w.regForm.rY][7:0]] = regs[w.immForm.rX];
                end
                default: ; // opcode 111
            endcase
            pc = pcNext;
            steps++;
        end
        if (!done) begin
            $display("Program %0d: the model never reached the final self branch", progNum);
            errors++;
        end
    endtask

    task automatic checkResetState();
        checkValue("DataValid", 16'(DataValid), '0);
        checkValue("DataWrite", 16'(DataWrite), '0);
        checkValue("InstrAddr", InstrAddr, '0);
    endtask

    task automatic runProgram(input int kind, input int pct);
        int expected;
        int cycles;
        @(negedge Clock);
        Reset = 1'b1;
        progNum++;
        readyPct   = pct;
        storesSeen = 0;
        expAddr.delete();
        expData.delete();
        buildProgram(kind);
        for (int a = 0; a < 256; a++) begin
            dmem[a]     = 16'($urandom);
            modelMem[a] = dmem[a];
        end
        runModel();
        expected = expAddr.size();
        repeat (10) begin
            @(negedge Clock);
            checkResetState();
        end
        Reset = 1'b0;
        @(negedge Clock); // one rising edge out of reset
        checkValue("DataValid", 16'(DataValid), '0);
        checkValue("DataWrite", 16'(DataWrite), '0);
        checkValue("InstrAddr", InstrAddr, 16'd1); // word 0 fetched, fetch moved on
        for (int n = 0; n < expected; n++) begin
            cycles = 0;
            while (storesSeen <= n && cycles < MaxWait) begin
                @(negedge Clock);
                cycles++;
            end
            if (storesSeen <= n) begin
                $display("Program %0d: store %0d of %0d did not arrive within %0d cycles",
                         progNum, n + 1, expected, MaxWait);
                errors++;
                break;
            end
        end
        repeat (20) @(negedge Clock); // a stray store would land here
        storesTotal += storesSeen;
    endtask

    // inputs change on the falling edge only
    always @(negedge Clock) begin
        InstrIn = imem[InstrAddr[ImemBits-1:0]];
        if (Reset) begin
            DataReady = 1'b0;
            waiting   = 1'b0;
        end else begin
            DataReady = ($urandom % 100) < readyPct;
            if (waiting) begin // request must not move while it waits
                checkValue("DataValid", 16'(DataValid), 16'd1);
                checkValue("DataAddr", DataAddr, heldAddr);
                checkValue("DataOut", DataOut, heldOut);
                checkValue("DataWrite", 16'(DataWrite), 16'(heldWrite));
            end
            DataIn = dmem[DataAddr[7:0]];
            if (DataValid && DataReady && DataWrite) begin // store lands on the next rising edge
                if (expAddr.size() == 0) begin
                    $display("Program %0d: store of %h to %h is beyond the model's stores",
                             progNum, DataOut, DataAddr);
                    errors++;
                end else begin
                    checkValue("DataAddr", DataAddr, expAddr.pop_front());
                    checkValue("DataOut", DataOut, expData.pop_front());
                end
                dmem[DataAddr[7:0]] = DataOut;
                storesSeen++;
            end
            waiting   = DataValid && !DataReady;
            heldAddr  = DataAddr;
            heldOut   = DataOut;
            heldWrite = DataWrite;
        end
    end

    initial begin
        void'($urandom(9));
        Reset       = 1'b1;
        InstrIn     = '0;
        DataReady   = 1'b0;
        DataIn      = '0;
        readyPct    = 100;
        errors      = 0;
        progNum     = 0;
        storesSeen  = 0;
        storesTotal = 0;
        waiting     = 1'b0;
        runProgram(0, 100);                              // alu only, both forms
        runProgram(WithMem, 100);
        runProgram(WithMem, 35);                         // long back pressure
        runProgram(WithBranch, 80);
        runProgram(WithMem | WithBranch, 60);
        runProgram(WithNop, 100);
        runProgram(WithMem | WithBranch | WithNop, 50);
        $display("%0d programs, %0d stores checked, %0d errors", progNum, storesTotal, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* build.f */
+incdir+.
isaPkg.sv
pipePkg.sv
regFileBus.sv
dataBus.sv
regFile.sv
frontEnd.sv
executeStage.sv
memWriteback.sv
cpuCore.sv
cpuTb.sv

/* run.sh */
#!/bin/sh
# build the core and testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module cpuTb -f build.f \
    && ./obj_dir/VcpuTb > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
